// File: Makefile
TOP := coreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f list.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: list.f
+incdir+sim
verilog/corePkg.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/executeUnit.sv
verilog/riscCore.sv
sim/coreTb.sv

// File: sim/programTable.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// test program for the RV32I core and the
// commits it must produce, in program order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef programTableSvh
`define programTableSvh

localparam int programLen  = 63;  // word 63 onward reads as zero and ends the program
localparam int expectCount = 37;

// x1 = 5 and x2 = -3 from here on, branch shadows write x31 and must never commit
localparam corePkg::wordT programWords [programLen] = '{
  32'h00500093, 32'hFFD00113,  // 00 addi x1,x0,5    addi x2,x0,-3
  32'h00F14193, 32'h00309213,  // 08 xori x3,x2,15   slli x4,x1,3
  32'h40115293, 32'h01C15313,  // 10 srai x5,x2,1    srli x6,x2,28
  32'h00112393, 32'hFFF0B413,  // 18 slti x7,x2,1    sltiu x8,x1,-1
  32'h002084B3, 32'h40208533,  // 20 add x9,x1,x2    sub x10,x1,x2
  32'h001095B3, 32'h00112633,  // 28 sll x11,x1,x1   slt x12,x2,x1
  32'h001136B3, 32'h0020C733,  // 30 sltu x13,x2,x1  xor x14,x1,x2
  32'h001157B3, 32'h40115833,  // 38 srl x15,x2,x1   sra x16,x2,x1
  32'h0020E8B3, 32'h0020F933,  // 40 or x17,x1,x2    and x18,x1,x2
  32'h00700993, 32'h01398A33,  // 48 addi x19,x0,7   add x20,x19,x19
  32'h413A0AB3, 32'h001A8013,  // 50 sub x21,x20,x19 addi x0,x21,1
  32'h000A8B33,                // 58 add x22,x21,x0
  // from 5c, per condition: taken branch +12, two shadows, target x23 = n,
  // then a not-taken branch +8 over x24 = n
  32'h00108663, 32'hFFF00F93, 32'hFFF00F93,  // beq x1,x1
  32'h00100B93, 32'h00208463, 32'h00100C13,  // beq x1,x2
  32'h00209663, 32'hFFF00F93, 32'hFFF00F93,  // bne x1,x2
  32'h00200B93, 32'h00109463, 32'h00200C13,  // bne x1,x1
  32'h00114663, 32'hFFF00F93, 32'hFFF00F93,  // blt x2,x1
  32'h00300B93, 32'h0020C463, 32'h00300C13,  // blt x1,x2
  32'h0020D663, 32'hFFF00F93, 32'hFFF00F93,  // bge x1,x2
  32'h00400B93, 32'h00115463, 32'h00400C13,  // bge x2,x1
  32'h0020E663, 32'hFFF00F93, 32'hFFF00F93,  // bltu x1,x2
  32'h00500B93, 32'h00116463, 32'h00500C13,  // bltu x2,x1
  32'h00117663, 32'hFFF00F93, 32'hFFF00F93,  // bgeu x2,x1
  32'h00600B93, 32'h0020F463, 32'h00600C13,  // bgeu x1,x2
  32'h12345CB7, 32'h00001D17,  // ec lui x25,0x12345  auipc x26,1
  32'hABCDE037, 32'hFFFFFD97   // f4 lui x0,0xabcde   auipc x27,0xfffff
};

// one row per expected commit, test is the group it is reported under
typedef struct packed {
  logic [2:0]       test;
  corePkg::regAddrT rd;
  corePkg::wordT    data;
} expectRowT;

localparam expectRowT expectTable [expectCount] = '{
  '{3'd0, 5'd1, 32'h00000005}, '{3'd0, 5'd2, 32'hFFFFFFFD}, '{3'd0, 5'd3, 32'hFFFFFFF2},
  '{3'd0, 5'd4, 32'h00000028}, '{3'd0, 5'd5, 32'hFFFFFFFE}, '{3'd0, 5'd6, 32'h0000000F},
  '{3'd0, 5'd7, 32'h00000001}, '{3'd0, 5'd8, 32'h00000001},
  '{3'd1, 5'd9, 32'h00000002}, '{3'd1, 5'd10, 32'h00000008}, '{3'd1, 5'd11, 32'h000000A0},
  '{3'd1, 5'd12, 32'h00000001}, '{3'd1, 5'd13, 32'h00000000}, '{3'd1, 5'd14, 32'hFFFFFFF8},
  '{3'd1, 5'd15, 32'h07FFFFFF}, '{3'd1, 5'd16, 32'hFFFFFFFF}, '{3'd1, 5'd17, 32'hFFFFFFFD},
  '{3'd1, 5'd18, 32'h00000005},
  '{3'd2, 5'd19, 32'h00000007}, '{3'd2, 5'd20, 32'h0000000E}, '{3'd2, 5'd21, 32'h00000007},
  '{3'd2, 5'd22, 32'h00000007},  // x0 write in between leaves no commit
  '{3'd3, 5'd23, 32'h00000001}, '{3'd3, 5'd24, 32'h00000001}, '{3'd3, 5'd23, 32'h00000002},
  '{3'd3, 5'd24, 32'h00000002}, '{3'd3, 5'd23, 32'h00000003}, '{3'd3, 5'd24, 32'h00000003},
  '{3'd3, 5'd23, 32'h00000004}, '{3'd3, 5'd24, 32'h00000004}, '{3'd3, 5'd23, 32'h00000005},
  '{3'd3, 5'd24, 32'h00000005}, '{3'd3, 5'd23, 32'h00000006}, '{3'd3, 5'd24, 32'h00000006},
  '{3'd4, 5'd25, 32'h12345000}, '{3'd4, 5'd26, 32'h000010F0}, '{3'd4, 5'd27, 32'hFFFFF0F8}
};

function automatic string testName(input logic [2:0] test);
  case (test)
    3'd0:    return "immediate ops";
    3'd1:    return "register ops";
    3'd2:    return "forwarding chain";
    3'd3:    return "branches";
    default: return "upper immediates and x0";
  endcase
endfunction

`endif

// File: sim/coreTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the RV32I core that runs
// the program table, checks commits and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module coreTb;

  `include "programTable.svh"

  localparam int commitTimeout = 20;  // cycles to the next commit, longest after a taken branch
  localparam int haltTimeout   = 20;
  localparam int holdCycles    = 10;  // halt watched this long after it rises

  logic            clk;
  logic            rstN;
  corePkg::wordT   instWord;
  corePkg::wordT   instAddr;
  corePkg::commitT commit;
  logic            halt;

  int testErrors = 0;  // errors in the test now running
  int passCount  = 0;
  int failCount  = 0;

  riscCore DUT (
    .clk (clk), .rstN (rstN), .instWord (instWord),
    .instAddr (instAddr), .commit (commit), .halt (halt)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // instruction port model driven from instAddr on every falling edge
  initial
  begin
    instWord = '0;
    forever
    begin
      @(negedge clk);
      instWord = fetchWord(instAddr);
    end
  end

  function automatic corePkg::wordT fetchWord(input corePkg::wordT addr);
    int unsigned index;
    index = addr / corePkg::instBytes;
    if ($isunknown(addr) || index >= programLen)
      return '0;  // past the table
    return programWords[index];
  endfunction

  // waits for the next commit pulse and samples it mid-cycle
  task automatic waitCommit(output corePkg::commitT got, output logic seen);
    int cycles;
    seen = 1'b0;
    got = '0;
    cycles = 0;
    while (!seen && cycles < commitTimeout)
    begin
      @(negedge clk);
      cycles++;
      if (commit.valid)
      begin
        seen = 1'b1;
        got = commit;
      end
    end
  endtask

  task automatic checkCommit(input corePkg::commitT got, input corePkg::commitT want);
    if (got.rd !== want.rd)
    begin
      $display("ERROR t=%0t commit.rd got %0d expected %0d", $time, got.rd, want.rd);
      testErrors++;
    end
    if (got.data !== want.data)
    begin
      $display("ERROR t=%0t commit.data got %h expected %h", $time, got.data, want.data);
      testErrors++;
    end
  endtask

  task automatic checkHalt(input logic got, input logic want);
    if (got !== want)
    begin
      $display("ERROR t=%0t halt got %b expected %b", $time, got, want);
      testErrors++;
    end
  endtask

  task automatic checkAddr(input corePkg::wordT got, input corePkg::wordT want);
    if (got !== want)
    begin
      $display("ERROR t=%0t instAddr got %h expected %h", $time, got, want);
      testErrors++;
    end
  endtask

  task automatic finishTest(input string name);
    if (testErrors == 0)
    begin
      $display("test %s: ok", name);
      passCount++;
    end
    else
    begin
      $display("test %s: %0d errors", name, testErrors);
      failCount++;
    end
    testErrors = 0;
  endtask

  initial
  begin
    expectRowT       row;
    corePkg::commitT got;
    corePkg::commitT want;
    corePkg::wordT   stopAddr;
    logic            seen;
    logic            lastOfTest;
    int              extra;
    int              cycles;
    rstN = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    for (int i = 0; i < expectCount; i++)
    begin
      row = expectTable[i];
      want.valid = 1'b1;
      want.rd = row.rd;
      want.data = row.data;
      waitCommit(got, seen);
      if (!seen)
      begin
        $display("no commit of x%0d arrived within %0d cycles", row.rd, commitTimeout);
        testErrors++;
      end
      else
        checkCommit(got, want);
      if (i == expectCount - 1)
        lastOfTest = 1'b1;
      else
        lastOfTest = (expectTable[i + 1].test != row.test);
      if (lastOfTest)
        finishTest(testName(row.test));
    end

    // after the last commit halt must rise and hold with nothing more committed
    stopAddr = programLen * corePkg::instBytes;  // first word past the table reads as zero
    extra = 0;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < haltTimeout)
    begin
      @(negedge clk);
      cycles++;
      if (commit.valid)
        extra++;
      if (halt)
        seen = 1'b1;
    end
    if (!seen)
    begin
      $display("halt did not rise within %0d cycles of the last commit", haltTimeout);
      testErrors++;
    end
    else
    begin
      for (cycles = 0; cycles < holdCycles; cycles++)
      begin
        @(negedge clk);
        if (commit.valid)
          extra++;
        checkHalt(halt, 1'b1);
        checkAddr(instAddr, stopAddr);  // fetch parked on the zero word
      end
    end
    if (extra != 0)
    begin
      $display("%0d commits arrived after the last expected one", extra);
      testErrors++;
    end
    finishTest("end of program");

    $display("tests passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/aluUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I integer ALU, purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
  input  wire corePkg::wordT     opA,
  input  wire corePkg::wordT     opB,
  input  wire corePkg::aluFuncT  func,
  input  wire                    altFunc,
  output corePkg::wordT          result
);

  logic [4:0] shamt;
  logic       lessSigned;
  logic       lessUnsigned;

  assign shamt        = opB[4:0];  // only low five bits count
  assign lessSigned   = $signed(opA) < $signed(opB);
  assign lessUnsigned = opA < opB;

  always_comb
  begin
    case (func)
      corePkg::aluAdd:  result = altFunc ? (opA - opB) : (opA + opB);
      corePkg::aluSll:  result = opA << shamt;
      corePkg::aluSlt:  result = {{(corePkg::wordBits-1){1'b0}}, lessSigned};
      corePkg::aluSltu: result = {{(corePkg::wordBits-1){1'b0}}, lessUnsigned};
      corePkg::aluXor:  result = opA ^ opB;
      corePkg::aluSrl:
        if (altFunc)
          result = $signed(opA) >>> shamt;  // sra keeps the sign
        else
          result = opA >> shamt;
      corePkg::aluOr:   result = opA | opB;
      corePkg::aluAnd:  result = opA & opB;
      default:          result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/corePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core package for the four-stage RV32I pipeline
// widths, opcodes, funct3 codes and stage payload structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package corePkg;

  localparam int wordBits = 32;  // data and address width
  localparam int regCount = 32;  // architectural registers

  typedef logic [wordBits-1:0] wordT;
  typedef logic [4:0] regAddrT;

  localparam wordT resetPc = '0;  // first fetch address
  localparam wordT instBytes = 'd4;  // pc step, no compressed isa

  // major opcodes, anything else retires as a no-op
  typedef enum logic [6:0] {
    opCompute = 7'b0110011,
    opImm     = 7'b0010011,
    opBranch  = 7'b1100011,
    opLui     = 7'b0110111,
    opAuipc   = 7'b0010111
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd  = 3'b000,  // also sub with altFunc
    aluSll  = 3'b001,
    aluSlt  = 3'b010,
    aluSltu = 3'b011,
    aluXor  = 3'b100,
    aluSrl  = 3'b101,  // also sra with altFunc
    aluOr   = 3'b110,
    aluAnd  = 3'b111
  } aluFuncT;

  // 010 and 011 are undefined, resolved as not taken
  typedef enum logic [2:0] {
    brEq  = 3'b000,
    brNe  = 3'b001,
    brLt  = 3'b100,
    brGe  = 3'b101,
    brLtu = 3'b110,
    brGeu = 3'b111
  } branchFuncT;

  typedef struct packed {
    logic valid;
    wordT pc;
    wordT inst;
  } fetchedT;  // fetch to decode

  typedef struct packed {
    logic    valid;
    wordT    pc;
    opcodeT  opcode;
    logic [2:0] funct3;
    logic    altFunc;  // sub / sra select
    regAddrT rs1;
    regAddrT rs2;
    regAddrT rd;
    wordT    imm;  // sign extended by format
  } decodedT;  // decode to execute

  typedef struct packed {
    logic    valid;
    regAddrT rd;
    wordT    data;
  } commitT;  // execute to writeback, also the commit port

  typedef struct packed {
    logic valid;
    wordT target;
  } redirectT;  // taken branch back to fetch

endpackage

`default_nettype wire

// File: verilog/decodeUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage: field split and immediate
// generation into the decode register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module decodeUnit (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire corePkg::fetchedT   fetched,
  input  wire corePkg::redirectT  redirect,
  output corePkg::decodedT        decoded
);

  corePkg::wordT    inst;
  corePkg::wordT    immI;
  corePkg::wordT    immB;
  corePkg::wordT    immU;
  corePkg::decodedT decodeNext;

  assign inst = fetched.inst;

  // immediates per format, all sign extended from bit 31
  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};

  always_comb
  begin
    decodeNext.valid   = fetched.valid;
    decodeNext.pc      = fetched.pc;
    decodeNext.opcode  = corePkg::opcodeT'(inst[6:0]);
    decodeNext.funct3  = inst[14:12];
    decodeNext.rs1     = inst[19:15];
    decodeNext.rs2     = inst[24:20];
    decodeNext.rd      = inst[11:7];
    decodeNext.altFunc = 1'b0;
    decodeNext.imm     = immI;  // I-type by default, shamt sits in imm[4:0]
    case (decodeNext.opcode)
      corePkg::opCompute:
        decodeNext.altFunc = inst[30];  // sub, sra
      corePkg::opImm:
        decodeNext.altFunc = inst[30] && (inst[13:12] == 2'b01);  // only srai, never addi
      corePkg::opBranch:
        decodeNext.imm = immB;
      corePkg::opLui, corePkg::opAuipc:
        decodeNext.imm = immU;
      default:
        decodeNext.imm = immI;  // unknown opcodes pass through, execute ignores them
    endcase
  end

  // decode register, squashed in the same cycle a branch redirects
  always_ff @(posedge clk)
  begin
    decoded <= decodeNext;
    if (!rstN || redirect.valid)
      decoded.valid <= 1'b0;
  end

endmodule

`default_nettype wire

// File: verilog/executeUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage: forwarding, ALU, branch
// resolve and the writeback register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire corePkg::decodedT   decoded,
  input  wire corePkg::wordT      rdData1,
  input  wire corePkg::wordT      rdData2,
  input  wire                     fetchValid,
  output corePkg::regAddrT        rs1,
  output corePkg::regAddrT        rs2,
  output corePkg::redirectT       redirect,
  output corePkg::commitT         wbCommit,
  output logic                    drained
);

  corePkg::wordT opA;
  corePkg::wordT opB;
  corePkg::wordT aluB;
  corePkg::wordT aluResult;
  corePkg::wordT result;
  logic          fwdOk;   // writeback holds a live nonzero rd
  logic          writes;  // opcode produces a register result
  logic          taken;

  assign rs1 = decoded.rs1;
  assign rs2 = decoded.rs2;

  // the register file write lands at this edge, so take writeback directly
  assign fwdOk = wbCommit.valid && (wbCommit.rd != '0);
  assign opA   = (fwdOk && wbCommit.rd == decoded.rs1) ? wbCommit.data : rdData1;
  assign opB   = (fwdOk && wbCommit.rd == decoded.rs2) ? wbCommit.data : rdData2;
  assign aluB  = (decoded.opcode == corePkg::opImm) ? decoded.imm : opB;

  aluUnit alu (
    .opA     (opA),
    .opB     (aluB),
    .func    (corePkg::aluFuncT'(decoded.funct3)),
    .altFunc (decoded.altFunc),
    .result  (aluResult)
  );

  always_comb
  begin
    writes = 1'b1;
    result = aluResult;
    case (decoded.opcode)
      corePkg::opCompute, corePkg::opImm: result = aluResult;
      corePkg::opLui:   result = decoded.imm;  // upper immediate as is
      corePkg::opAuipc: result = decoded.pc + decoded.imm;
      default:          writes = 1'b0;  // branches and unknowns
    endcase
  end

  // branch conditions compare the forwarded operands
  always_comb
  begin
    case (corePkg::branchFuncT'(decoded.funct3))
      corePkg::brEq:  taken = (opA == opB);
      corePkg::brNe:  taken = (opA != opB);
      corePkg::brLt:  taken = $signed(opA) < $signed(opB);
      corePkg::brGe:  taken = $signed(opA) >= $signed(opB);
      corePkg::brLtu: taken = opA < opB;
      corePkg::brGeu: taken = opA >= opB;
      default:        taken = 1'b0;
    endcase
    redirect.valid  = decoded.valid && (decoded.opcode == corePkg::opBranch) && taken;
    redirect.target = decoded.pc + decoded.imm;  // predict not taken, so taken = redirect
  end

  always_ff @(posedge clk)
  begin
    wbCommit.rd   <= decoded.rd;
    wbCommit.data <= result;
    if (!rstN)
      wbCommit.valid <= 1'b0;
    else
      wbCommit.valid <= decoded.valid && writes && (decoded.rd != '0);  // x0 writes dropped
  end

  assign drained = !decoded.valid && !fetchValid && !wbCommit.valid;

endmodule

`default_nettype wire

// File: verilog/fetchUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage: pc, fetch register, flush on
// taken branch and end-of-program halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetchUnit (
  input  wire                      clk,
  input  wire                      rstN,
  input  wire corePkg::wordT       instWord,
  input  wire corePkg::redirectT   redirect,
  input  wire                      drained,
  output corePkg::wordT            instAddr,
  output corePkg::fetchedT         fetched,
  output logic                     halt
);

  corePkg::wordT pc;
  logic stopped;   // all-zero word seen, pc frozen
  logic zeroWord;

  assign zeroWord = (instWord == '0);
  assign instAddr = pc;  // instruction port is combinational

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      pc      <= corePkg::resetPc;
      stopped <= 1'b0;
      halt    <= 1'b0;
    end
    else
    begin
      if (redirect.valid)
      begin
        pc      <= redirect.target;  // branch wins over everything, restarts a stopped fetch
        stopped <= 1'b0;
      end
      else if (!stopped)
      begin
        if (zeroWord)
          stopped <= 1'b1;  // hold instAddr on the zero word
        else
          pc <= pc + corePkg::instBytes;
      end
      if (stopped && drained)
        halt <= 1'b1;  // sticky until reset
    end
  end

  // fetch register, flushed by a redirect and empty while stopped
  always_ff @(posedge clk)
  begin
    fetched.pc   <= pc;
    fetched.inst <= instWord;
    if (!rstN)
      fetched.valid <= 1'b0;
    else
      fetched.valid <= !redirect.valid && !stopped && !zeroWord;
  end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer register file, 2 read / 1 write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module regFile (
  input  wire                    clk,
  input  wire corePkg::regAddrT  rs1,
  input  wire corePkg::regAddrT  rs2,
  input  wire corePkg::commitT   wr,
  output corePkg::wordT          rdData1,
  output corePkg::wordT          rdData2
);

  corePkg::wordT regs [corePkg::regCount];

  // reads are combinational, x0 always zero
  assign rdData1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdData2 = (rs2 == '0) ? '0 : regs[rs2];

  // commit never carries rd 0, so x0 is never written
  always_ff @(posedge clk)
  begin
    if (wr.valid)
      regs[wr.rd] <= wr.data;
  end

endmodule

`default_nettype wire

// File: verilog/riscCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core top: fetch, decode, execute,
// writeback with commit port and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module riscCore (
  input  wire                 clk,
  input  wire                 rstN,
  input  wire corePkg::wordT  instWord,
  output corePkg::wordT       instAddr,
  output corePkg::commitT     commit,
  output logic                halt
);

  corePkg::fetchedT  fetched;
  corePkg::decodedT  decoded;
  corePkg::redirectT redirect;
  corePkg::commitT   wbCommit;  // write port, forward source and commit
  corePkg::regAddrT  rs1;
  corePkg::regAddrT  rs2;
  corePkg::wordT     rdData1;
  corePkg::wordT     rdData2;
  logic              drained;

  fetchUnit fetchU (
    .clk (clk), .rstN (rstN),
    .instWord (instWord), .redirect (redirect), .drained (drained),
    .instAddr (instAddr), .fetched (fetched), .halt (halt)
  );

  decodeUnit decodeU (
    .clk (clk), .rstN (rstN),
    .fetched (fetched), .redirect (redirect), .decoded (decoded)
  );

  regFile regFileU (
    .clk (clk), .rs1 (rs1), .rs2 (rs2), .wr (wbCommit),
    .rdData1 (rdData1), .rdData2 (rdData2)
  );

  executeUnit executeU (
    .clk (clk), .rstN (rstN),
    .decoded (decoded), .rdData1 (rdData1), .rdData2 (rdData2),
    .fetchValid (fetched.valid),  // for the drain check
    .rs1 (rs1), .rs2 (rs2), .redirect (redirect),
    .wbCommit (wbCommit), .drained (drained)
  );

  assign commit = wbCommit;

endmodule

`default_nettype wire
